// File: cpuPkg.sv
package cpuPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction encodings
    ////////////////////////////////////////////////////////////////////////////

    // Major opcodes, bits 31:26 of the word
    typedef enum logic [5:0] {
        opRtype = 6'd0,
        opAddi  = 6'd8,
        opLw    = 6'd35,
        opSw    = 6'd43
    } opcodeT;

    // Function field of R-type words, bits 5:0
    typedef enum logic [5:0] {
        fnAdd = 6'd32,
        fnSub = 6'd34,
        fnAnd = 6'd36,
        fnOr  = 6'd37,
        fnSlt = 6'd42
    } functT;

    // Operations the execute stage knows
    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt
    } aluOpT;

    ////////////////////////////////////////////////////////////////////////////
    // Pipeline stage records
    ////////////////////////////////////////////////////////////////////////////

    // Decode to execute
    typedef struct packed {
        logic        valid;
        aluOpT       aluOp;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  dest;
        logic [31:0] imm;
        logic        useImm;
        logic        memRead;
        logic        memWrite;
        logic        regWrite;
    } decodedT;

    // Execute to memory and writeback
    typedef struct packed {
        logic        valid;
        logic [31:0] aluResult;
        logic [31:0] storeData;
        logic [4:0]  dest;
        logic        memRead;
        logic        memWrite;
        logic        regWrite;
    } execT;

    // One finished instruction
    typedef struct packed {
        logic        valid;
        logic [4:0]  dest;
        logic        regWrite;
        logic [31:0] data;
    } retireT;

endpackage

// File: instrDecode.sv
`timescale 1ns/100ps

module instrDecode (
    input  logic              clk,
    input  logic              rst,
    input  logic              instrValid,
    input  logic [31:0]       instr,
    output logic [4:0]        rsIdx,
    output logic [4:0]        rtIdx,
    output cpuPkg::decodedT   decoded,
    output logic              illegal
);

    // Instruction fields
    cpuPkg::opcodeT  opcode;
    cpuPkg::functT   funct;
    logic [4:0]      rdIdx;
    logic [15:0]     immField;

    // Decoded control, before the stage register
    cpuPkg::decodedT nextDec;
    logic            known;

    assign opcode   = cpuPkg::opcodeT'(instr[31:26]);
    assign funct    = cpuPkg::functT'(instr[5:0]);
    assign rdIdx    = instr[15:11];
    assign immField = instr[15:0];

    // Read indices go straight to the register file
    assign rsIdx = instr[25:21];
    assign rtIdx = instr[20:16];

    always_comb
    begin
        // Defaults describe an I-type word writing rt
        nextDec.valid    = 1'b0;
        nextDec.aluOp    = cpuPkg::aluAdd;
        nextDec.rs       = rsIdx;
        nextDec.rt       = rtIdx;
        nextDec.dest     = rtIdx;
        nextDec.imm      = {{16{immField[15]}}, immField};
        nextDec.useImm   = 1'b0;
        nextDec.memRead  = 1'b0;
        nextDec.memWrite = 1'b0;
        nextDec.regWrite = 1'b0;
        known            = 1'b1;
        case (opcode)
            cpuPkg::opRtype:
            begin
                nextDec.dest     = rdIdx;
                nextDec.regWrite = 1'b1;
                // Function code picks the ALU op
                case (funct)
                    cpuPkg::fnAdd: nextDec.aluOp = cpuPkg::aluAdd;
                    cpuPkg::fnSub: nextDec.aluOp = cpuPkg::aluSub;
                    cpuPkg::fnAnd: nextDec.aluOp = cpuPkg::aluAnd;
                    cpuPkg::fnOr:  nextDec.aluOp = cpuPkg::aluOr;
                    cpuPkg::fnSlt: nextDec.aluOp = cpuPkg::aluSlt;
                    default:       known = 1'b0;
                endcase
            end
            cpuPkg::opAddi:
            begin
                nextDec.useImm   = 1'b1;
                nextDec.regWrite = 1'b1;
            end
            cpuPkg::opLw:
            begin
                // Address is base plus offset
                nextDec.useImm   = 1'b1;
                nextDec.memRead  = 1'b1;
                nextDec.regWrite = 1'b1;
            end
            cpuPkg::opSw:
            begin
                nextDec.useImm   = 1'b1;
                nextDec.memWrite = 1'b1;
            end
            default: known = 1'b0;
        endcase
        // Unknown words never enter the pipe
        nextDec.valid = instrValid & known;
    end

    // Stage register, edge 0
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            decoded <= '0;
            illegal <= 1'b0;
        end
        else
        begin
            decoded <= nextDec;
            illegal <= instrValid & ~known;
        end
    end

endmodule

// File: regFile.sv
`timescale 1ns/100ps

module regFile (
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  rsIdx,
    input  logic [4:0]  rtIdx,
    output logic [31:0] rsData,
    output logic [31:0] rtData,
    input  logic        wrEn,
    input  logic [4:0]  wrAddr,
    input  logic [31:0] wrData
);

    logic [31:0] regs [32];
    logic        wrLive;

    // Register 0 is hardwired, never written
    assign wrLive = wrEn && (wrAddr != 5'd0);

    // One read port, with write-through from the same edge
    function automatic logic [31:0] readPort(input logic [4:0] idx);
        logic [31:0] value;
        if (idx == 5'd0)
            value = '0;
        else if (wrLive && (wrAddr == idx))
            value = wrData;
        else
            value = regs[idx];
        return value;
    endfunction

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < 32; i++)
            begin
                regs[i] <= '0;
            end
            rsData <= '0;
            rtData <= '0;
        end
        else
        begin
            if (wrLive)
            begin
                regs[wrAddr] <= wrData;
            end
            // Captured alongside the decode register
            rsData <= readPort(rsIdx);
            rtData <= readPort(rtIdx);
        end
    end

endmodule

// File: aluExecute.sv
`timescale 1ns/100ps

module aluExecute (
    input  logic            clk,
    input  logic            rst,
    input  cpuPkg::decodedT decoded,
    input  logic [31:0]     rsData,
    input  logic [31:0]     rtData,
    output cpuPkg::execT    exec
);

    logic [31:0] opB;
    logic [31:0] aluOut;

    // Operand B mux
    assign opB = decoded.useImm ? decoded.imm : rtData;

    ////////////////////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        case (decoded.aluOp)
            cpuPkg::aluAdd: aluOut = rsData + opB;
            cpuPkg::aluSub: aluOut = rsData - opB;
            cpuPkg::aluAnd: aluOut = rsData & opB;
            cpuPkg::aluOr:  aluOut = rsData | opB;
            // Signed compare, 1 or 0
            cpuPkg::aluSlt: aluOut = {31'd0, $signed(rsData) < $signed(opB)};
            default:        aluOut = '0;
        endcase
    end

    // Stage register, edge 1
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            exec <= '0;
        end
        else
        begin
            exec.valid     <= decoded.valid;
            exec.aluResult <= aluOut;
            // Store data is the rt operand
            exec.storeData <= rtData;
            exec.dest      <= decoded.dest;
            exec.memRead   <= decoded.memRead;
            exec.memWrite  <= decoded.memWrite;
            exec.regWrite  <= decoded.regWrite;
        end
    end

endmodule

// File: dataMemory.sv
`timescale 1ns/100ps

module dataMemory #(
    parameter int MemWords = 32
) (
    input  logic         clk,
    input  logic         rst,
    input  cpuPkg::execT exec,
    output logic [31:0]  loadData,
    input  logic         debugOn,
    input  logic [31:0]  debugAddr,
    output logic [31:0]  debugData
);

    localparam int AddrW = $clog2(MemWords);

    logic [31:0]      mem [MemWords];
    logic [AddrW-1:0] memAddr;
    logic [AddrW-1:0] dbgAddr;
    logic             doStore;
    logic             doLoad;

    // Word index, upper bits dropped so addresses wrap
    assign memAddr = exec.aluResult[AddrW-1:0];
    assign dbgAddr = debugAddr[AddrW-1:0];

    assign doStore = exec.valid & exec.memWrite;
    assign doLoad  = exec.valid & exec.memRead;

    ////////////////////////////////////////////////////////////////////////////
    // Load and store port, edge 2
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            // Every word cleared
            for (int i = 0; i < MemWords; i++)
            begin
                mem[i] <= '0;
            end
            loadData <= '0;
        end
        else
        begin
            if (doStore)
            begin
                mem[memAddr] <= exec.storeData;
            end
            if (doLoad)
            begin
                loadData <= mem[memAddr];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Debug read port
    ////////////////////////////////////////////////////////////////////////////

    // Separate path, no stall of the main port
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            debugData <= '0;
        end
        else if (debugOn)
        begin
            debugData <= mem[dbgAddr];
        end
    end

endmodule

// File: resultWriteback.sv
`timescale 1ns/100ps

module resultWriteback (
    input  logic           clk,
    input  logic           rst,
    input  cpuPkg::execT   exec,
    input  logic [31:0]    loadData,
    output logic           wrEn,
    output logic [4:0]     wrAddr,
    output logic [31:0]    wrData,
    output cpuPkg::retireT retire
);

    // Exec delayed to line up with loadData
    cpuPkg::execT execQ;
    logic [31:0]  resultData;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            execQ <= '0;
        end
        else
        begin
            execQ <= exec;
        end
    end

    // Load value for LW, else the ALU result
    // SW reports its store address here
    assign resultData = execQ.memRead ? loadData : execQ.aluResult;

    // Register write lands on edge 3
    assign wrEn   = execQ.valid & execQ.regWrite;
    assign wrAddr = execQ.dest;
    assign wrData = resultData;

    // Retire record, edge 3
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            retire <= '0;
        end
        else
        begin
            retire.valid    <= execQ.valid;
            retire.dest     <= execQ.dest;
            retire.regWrite <= execQ.regWrite;
            retire.data     <= resultData;
        end
    end

endmodule

// File: miniCore.sv
`timescale 1ns/100ps

module miniCore #(
    parameter int MemWords = 32
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           instrValid,
    input  logic [31:0]    instr,
    output cpuPkg::retireT retire,
    output logic           illegal,
    input  logic           debugOn,
    input  logic [31:0]    debugAddr,
    output logic [31:0]    debugData
);

    ////////////////////////////////////////////////////////////////////////////
    // Stage links
    ////////////////////////////////////////////////////////////////////////////

    logic [4:0]      rsIdx;
    logic [4:0]      rtIdx;
    logic [31:0]     rsData;
    logic [31:0]     rtData;
    cpuPkg::decodedT decoded;
    cpuPkg::execT    exec;
    logic [31:0]     loadData;

    // Register write port
    logic            wrEn;
    logic [4:0]      wrAddr;
    logic [31:0]     wrData;

    instrDecode decode_i (
        .clk        (clk),
        .rst        (rst),
        .instrValid (instrValid),
        .instr      (instr),
        .rsIdx      (rsIdx),
        .rtIdx      (rtIdx),
        .decoded    (decoded),
        .illegal    (illegal)
    );

    regFile regs_i (
        .clk    (clk),
        .rst    (rst),
        .rsIdx  (rsIdx),
        .rtIdx  (rtIdx),
        .rsData (rsData),
        .rtData (rtData),
        .wrEn   (wrEn),
        .wrAddr (wrAddr),
        .wrData (wrData)
    );

    aluExecute execute_i (
        .clk     (clk),
        .rst     (rst),
        .decoded (decoded),
        .rsData  (rsData),
        .rtData  (rtData),
        .exec    (exec)
    );

    // Memory depth set here
    dataMemory #(
        .MemWords (MemWords)
    ) memory_i (
        .clk       (clk),
        .rst       (rst),
        .exec      (exec),
        .loadData  (loadData),
        .debugOn   (debugOn),
        .debugAddr (debugAddr),
        .debugData (debugData)
    );

    resultWriteback writeback_i (
        .clk      (clk),
        .rst      (rst),
        .exec     (exec),
        .loadData (loadData),
        .wrEn     (wrEn),
        .wrAddr   (wrAddr),
        .wrData   (wrData),
        .retire   (retire)
    );

endmodule

// File: tbClock.sv
`timescale 1ns/100ps

module tbClock (
    input  logic resetReq,
    output logic clk,
    output logic rst
);

    localparam int HalfPeriod  = 20;
    localparam int ResetCycles = 5;

    logic clkGen  = 1'b0;
    logic rstHold = 1'b1;

    // Rising edges left with reset held
    int holdEdges = ResetCycles;

    always #HalfPeriod clkGen = ~clkGen;

    // A request restarts the reset window
    always @(posedge clkGen)
    begin
        if (resetReq)
            holdEdges <= ResetCycles;
        else if (holdEdges > 0)
            holdEdges <= holdEdges - 1;
    end

    // Reset changes on the falling edge, like every other input
    always @(negedge clkGen)
    begin
        rstHold <= (holdEdges > 0);
    end

    assign clk = clkGen;
    assign rst = rstHold;

endmodule

// File: tbMiniCore.sv
`timescale 1ns/100ps

module tbMiniCore;

    localparam int MemWords      = 32;
    localparam int AddrW         = $clog2(MemWords);
    // Tests run for roughly 400 cycles
    localparam int TimeoutCycles = 2000;

    logic           clk;
    logic           rst;
    logic           resetReq;
    logic           instrValid;
    logic [31:0]    instr;
    cpuPkg::retireT retire;
    logic           illegal;
    logic           debugOn;
    logic [31:0]    debugAddr;
    logic [31:0]    debugData;

    // Reference state of the core
    logic [31:0] refRegs [32];
    logic [31:0] refMem [MemWords];

    // Outstanding results and the edge each one is due
    cpuPkg::retireT expRetire[$];
    int             expEdge[$];
    int             illegalEdge[$];

    string testName    = "startup";
    int    edgeCount   = 0;
    int    checkCount  = 0;
    int    valueErrors = 0;
    int    otherErrors = 0;

    tbClock clock_i (
        .resetReq (resetReq),
        .clk      (clk),
        .rst      (rst)
    );

    miniCore #(
        .MemWords (MemWords)
    ) dut_i (
        .clk        (clk),
        .rst        (rst),
        .instrValid (instrValid),
        .instr      (instr),
        .retire     (retire),
        .illegal    (illegal),
        .debugOn    (debugOn),
        .debugAddr  (debugAddr),
        .debugData  (debugData)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Checking helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic checkValue(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (actual !== expected)
        begin
            valueErrors++;
            $display("ERR %s %s: expected %h, actual %h", testName, what, expected, actual);
        end
    endtask

    task automatic reportFault(input string msg);
        otherErrors++;
        $display("Failure in %s: %s at edge %0d", testName, msg, edgeCount);
    endtask

    // Edge count and watchdog
    always @(posedge clk)
    begin
        edgeCount <= edgeCount + 1;
        if (edgeCount >= TimeoutCycles)
        begin
            $display("Timeout: the tests did not finish within %0d cycles", TimeoutCycles);
            $display("sim failed");
            $finish;
        end
    end

    // Retire and illegal outputs sampled mid-cycle
    always @(negedge clk)
    begin
        if (!rst)
        begin
            if (retire.valid)
            begin
                if (expRetire.size() == 0)
                begin
                    reportFault("retire with no instruction outstanding");
                end
                else
                begin
                    checkValue("retire edge", 32'(expEdge[0]), 32'(edgeCount));
                    checkValue("retire data", expRetire[0].data, retire.data);
                    checkValue("retire dest and regWrite",
                               {26'd0, expRetire[0].dest, expRetire[0].regWrite},
                               {26'd0, retire.dest, retire.regWrite});
                    expRetire.delete(0);
                    expEdge.delete(0);
                end
            end
            else if (expEdge.size() != 0 && expEdge[0] <= edgeCount)
            begin
                reportFault("expected retire did not appear");
                expRetire.delete(0);
                expEdge.delete(0);
            end
            if (illegal)
            begin
                if (illegalEdge.size() != 0 && illegalEdge[0] == edgeCount)
                    illegalEdge.delete(0);
                else
                    reportFault("illegal pulse with no illegal word issued");
            end
            else if (illegalEdge.size() != 0 && illegalEdge[0] <= edgeCount)
            begin
                reportFault("illegal pulse missing");
                illegalEdge.delete(0);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Instruction words and the reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] rType(input logic [5:0] fn, input logic [4:0] rd,
                                          input logic [4:0] rs, input logic [4:0] rt);
        return {6'd0, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rt,
                                          input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic clearModel();
        for (int i = 0; i < 32; i++)
            refRegs[i] = '0;
        for (int i = 0; i < MemWords; i++)
            refMem[i] = '0;
    endtask

    // Runs the word on the model and drives it for one cycle
    task automatic issue(input logic [31:0] word);
        logic [31:0]      a;
        logic [31:0]      b;
        logic [31:0]      ext;
        logic [31:0]      addr;
        logic [AddrW-1:0] idx;
        logic             known;
        cpuPkg::retireT   rec;
        a          = refRegs[word[25:21]];
        b          = refRegs[word[20:16]];
        ext        = {{16{word[15]}}, word[15:0]};
        addr       = a + ext;
        // Upper bits wrap away in the word index
        idx        = addr[AddrW-1:0];
        known      = 1'b1;
        rec.valid    = 1'b1;
        rec.dest     = word[20:16];
        rec.regWrite = 1'b1;
        rec.data     = addr;
        case (word[31:26])
            6'd0:
            begin
                rec.dest = word[15:11];
                case (word[5:0])
                    6'd32:   rec.data = a + b;
                    6'd34:   rec.data = a - b;
                    6'd36:   rec.data = a & b;
                    6'd37:   rec.data = a | b;
                    6'd42:   rec.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: known = 1'b0;
                endcase
            end
            6'd8:  rec.data = addr;
            6'd35: rec.data = refMem[idx];
            6'd43:
            begin
                // Store reports its address and writes no register
                rec.regWrite = 1'b0;
                refMem[idx]  = b;
            end
            default: known = 1'b0;
        endcase
        @(negedge clk);
        instr      = word;
        instrValid = 1'b1;
        if (known)
        begin
            expRetire.push_back(rec);
            expEdge.push_back(edgeCount + 4);
            if (rec.regWrite && rec.dest != 5'd0)
                refRegs[rec.dest] = rec.data;
        end
        else
        begin
            illegalEdge.push_back(edgeCount + 1);
        end
    endtask

    // Stop issuing and wait until every expected output has shown up
    task automatic drain();
        @(negedge clk);
        instrValid = 1'b0;
        instr      = '0;
        while (expRetire.size() != 0 || illegalEdge.size() != 0)
            @(negedge clk);
    endtask

    task automatic debugRead(input logic [31:0] addr);
        @(negedge clk);
        debugOn   = 1'b1;
        debugAddr = addr;
        @(negedge clk);
        checkValue("debug word", refMem[addr[AddrW-1:0]], debugData);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic aluOperations();
        logic [15:0] opA;
        logic [15:0] opB;
        testName = "alu";
        for (int n = 0; n < 4; n++)
        begin
            // First round pins a negative against a positive for signed SLT
            opA = (n == 0) ? 16'hFFFB : 16'($urandom());
            opB = (n == 0) ? 16'h0003 : 16'($urandom());
            issue(iType(cpuPkg::opAddi, 5'd1, 5'd0, opA));
            issue(iType(cpuPkg::opAddi, 5'd2, 5'd0, opB));
            drain();
            issue(rType(cpuPkg::fnAdd, 5'd3, 5'd1, 5'd2));
            issue(rType(cpuPkg::fnSub, 5'd4, 5'd1, 5'd2));
            issue(rType(cpuPkg::fnAnd, 5'd5, 5'd1, 5'd2));
            issue(rType(cpuPkg::fnOr, 5'd6, 5'd1, 5'd2));
            issue(rType(cpuPkg::fnSlt, 5'd7, 5'd1, 5'd2));
            issue(rType(cpuPkg::fnSlt, 5'd8, 5'd2, 5'd1));
            issue(iType(cpuPkg::opAddi, 5'd9, 5'd1, 16'($urandom())));
            drain();
        end
    endtask

    task automatic zeroRegister();
        testName = "register zero";
        issue(iType(cpuPkg::opAddi, 5'd0, 5'd0, 16'h1234));
        issue(iType(cpuPkg::opAddi, 5'd10, 5'd0, 16'h0007));
        drain();
        issue(rType(cpuPkg::fnAdd, 5'd0, 5'd10, 5'd10));
        drain();
        issue(rType(cpuPkg::fnAdd, 5'd11, 5'd0, 5'd0));
        issue(rType(cpuPkg::fnOr, 5'd12, 5'd0, 5'd10));
        drain();
    endtask

    task automatic storeThenLoad();
        testName = "load store";
        for (int n = 0; n < 4; n++)
        begin
            issue(iType(cpuPkg::opAddi, 5'd13, 5'd0, 16'($urandom_range(MemWords - 1, 0))));
            issue(iType(cpuPkg::opAddi, 5'd14, 5'd0, 16'($urandom())));
            drain();
            issue(iType(cpuPkg::opSw, 5'd14, 5'd13, 16'd0));
            drain();
            issue(iType(cpuPkg::opLw, 5'd15, 5'd13, 16'd0));
            drain();
        end
        // Past the end wraps onto index 3
        issue(iType(cpuPkg::opAddi, 5'd13, 5'd0, 16'(MemWords + 3)));
        drain();
        issue(iType(cpuPkg::opSw, 5'd14, 5'd13, 16'd0));
        drain();
        issue(iType(cpuPkg::opLw, 5'd15, 5'd0, 16'd3));
        drain();
    endtask

    task automatic memoryDebug();
        testName = "debug read";
        for (int n = 0; n < 4; n++)
            issue(iType(cpuPkg::opAddi, 5'(20 + n), 5'd0, 16'($urandom())));
        drain();
        for (int n = 0; n < 4; n++)
            issue(iType(cpuPkg::opSw, 5'(20 + n), 5'd0, 16'(8 + n)));
        drain();
        for (int n = 8; n < 12; n++)
            debugRead(32'(n));
        debugRead(32'(MemWords + 11));
        // Port off and address moved while the value stays
        @(negedge clk);
        debugOn   = 1'b0;
        debugAddr = 32'd8;
        repeat (2) @(negedge clk);
        checkValue("debug hold", refMem[11], debugData);
        // Watch word 11 while a store stream runs
        @(negedge clk);
        debugOn   = 1'b1;
        debugAddr = 32'd11;
        for (int n = 0; n < 8; n++)
        begin
            issue(iType(cpuPkg::opSw, 5'(20 + n % 4), 5'd0, 16'(12 + n)));
            checkValue("debug during stores", refMem[11], debugData);
        end
        drain();
        for (int n = 12; n < 20; n++)
            debugRead(32'(n));
        debugOn = 1'b0;
        for (int n = 0; n < 8; n++)
            issue(iType(cpuPkg::opLw, 5'(24 + n), 5'd0, 16'(12 + n)));
        drain();
    endtask

    task automatic illegalWords();
        testName = "illegal";
        issue({6'd63, 26'd0});
        drain();
        issue(rType(6'd39, 5'd16, 5'd1, 5'd2));
        drain();
        // Illegal words leave gaps in a back-to-back retire stream
        issue(iType(cpuPkg::opAddi, 5'd16, 5'd0, 16'h0101));
        issue(iType(cpuPkg::opAddi, 5'd17, 5'd0, 16'h0202));
        issue({6'd2, 26'd0});
        issue(iType(cpuPkg::opAddi, 5'd18, 5'd0, 16'h0303));
        issue(rType(6'd0, 5'd19, 5'd1, 5'd2));
        issue(iType(cpuPkg::opAddi, 5'd19, 5'd0, 16'h0404));
        drain();
    endtask

    task automatic resetClears();
        testName = "reset";
        @(negedge clk);
        resetReq = 1'b1;
        @(negedge clk);
        resetReq = 1'b0;
        wait (rst == 1'b1);
        wait (rst == 1'b0);
        clearModel();
        for (int n = 8; n < 20; n++)
            debugRead(32'(n));
        debugOn = 1'b0;
        issue(rType(cpuPkg::fnAdd, 5'd3, 5'd20, 5'd21));
        issue(rType(cpuPkg::fnOr, 5'd4, 5'd14, 5'd13));
        drain();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        resetReq   = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        debugOn    = 1'b0;
        debugAddr  = '0;
        void'($urandom(39));
        clearModel();
        wait (rst == 1'b0);
        aluOperations();
        zeroRegister();
        storeThenLoad();
        memoryDebug();
        illegalWords();
        resetClears();
        $display("Checks %0d, value errors %0d, other errors %0d",
                 checkCount, valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// File: verilog.f
cpuPkg.sv
instrDecode.sv
regFile.sv
aluExecute.sv
dataMemory.sv
resultWriteback.sv
miniCore.sv
tbClock.sv
tbMiniCore.sv

// File: Makefile
# Verilator flow for the mini core testbench

VERILATOR ?= verilator
TOP       ?= tbMiniCore
FILELIST  ?= verilog.f
BUILDDIR  ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SOURCES := $(shell cat $(FILELIST))
BINARY  := $(BUILDDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILDDIR) -f $(FILELIST)

# Pass or fail comes from the log, not the exit code of the binary
run: compile
	./$(BINARY) | tee $(LOG)
	@grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)
